// File: neoC1.f
verilog/c1Pkg.sv
verilog/c1AddrDecode.sv
verilog/c1Wait.sv
verilog/c1SoundLatch.sv
verilog/c1ReadPort.sv
verilog/neoC1.sv
test/neoC1Checker.sv
test/neoC1Tb.sv

// File: test/neoC1Tb.sv
// C1 bus glue testbench
`timescale 1ns/100ps

module neoC1Tb;
	import c1Pkg::*;

	localparam int clkPeriod = 4;
	localparam int romWaits  = 2;
	// Reset, decode, read port, wait states, sound
	localparam int busCycles = 1 + 200 + 30 + 40 + 2;

	logic clk68k = 1'b0;
	logic arstN;
	busReq cpuBus;
	dataByte dataIn, sddIn, dataOut, sddOut;
	padBits p1In, p2In;
	logic nCd1, nCd2, nWp, systemMode;
	logic nRomWait, nPWait0, nPWait1, pDtack;
	logic nSdZ80R, nSdZ80W, nSdZ80Clr;
	memStrobes strobes;
	logic dataOe, nDtack, sddOe, nSdw;

	// Reference results
	memStrobes expStrobes;
	dataByte   expData;
	dataByte   replyModel;
	logic      expOe;
	logic      expIcomWr;
	int        expWait;
	int        errorCount;
	int        checkCount;

	integer      seed = 32'hedd3_25a1;
	logic [31:0] rnd;
	logic [31:0] dtackRnd;
	cpuAddr      reqAddr;

	always #(clkPeriod / 2) clk68k = ~clk68k;

	neoC1 #(
		.romWaitStates (2'(romWaits))
	) DUT (
		.clk68k (clk68k), .arstN (arstN), .cpuBus (cpuBus), .dataIn (dataIn),
		.p1In (p1In), .p2In (p2In), .nCd1 (nCd1), .nCd2 (nCd2), .nWp (nWp),
		.systemMode (systemMode), .nRomWait (nRomWait), .nPWait0 (nPWait0),
		.nPWait1 (nPWait1), .pDtack (pDtack), .sddIn (sddIn), .nSdZ80R (nSdZ80R),
		.nSdZ80W (nSdZ80W), .nSdZ80Clr (nSdZ80Clr), .strobes (strobes),
		.dataOut (dataOut), .dataOe (dataOe), .nDtack (nDtack), .sddOut (sddOut),
		.sddOe (sddOe), .nSdw (nSdw)
	);

	neoC1Checker portCheck (
		.clk68k (clk68k), .arstN (arstN), .cpuBus (cpuBus), .dataIn (dataIn),
		.pDtack (pDtack), .nSdZ80R (nSdZ80R), .nSdZ80Clr (nSdZ80Clr),
		.strobes (strobes), .dataOut (dataOut), .dataOe (dataOe), .nDtack (nDtack),
		.sddOut (sddOut), .sddOe (sddOe), .nSdw (nSdw), .expStrobes (expStrobes),
		.expData (expData), .expOe (expOe), .expWait (expWait),
		.expIcomWr (expIcomWr), .errorCount (errorCount), .checkCount (checkCount)
	);

	function automatic logic inRange(input logic [23:0] a, input logic [23:0] lo,
			input logic [23:0] hi);
		return (a >= lo) && (a <= hi);
	endfunction

	// 128 KB register slot in 3xxxxx, -1 when no active upper-byte access there
	function automatic int regSel(input busReq b);
		if (b.nAs || b.nUds || !inRange({b.addr, 17'h0}, 24'h300000, 24'h3FFFFF)) begin
			return -1;
		end
		return int'(b.addr[2:0]);
	endfunction

	function automatic memStrobes refStrobes(input busReq b);
		logic [23:0] a;
		logic rd, wr, lo, up, io;
		logic rom, wram, port, lspc, pal, card, srom, sram;
		logic [2:0] sub;
		a    = {b.addr, 17'h0};
		rd   = !b.nAs && b.rw;
		wr   = !b.nAs && !b.rw;
		lo   = !b.nLds;
		up   = !b.nUds;
		sub  = b.addr[2:0];
		rom  = a <= 24'h0FFFFF;
		wram = inRange(a, 24'h100000, 24'h1FFFFF);
		port = inRange(a, 24'h200000, 24'h2FFFFF);
		io   = inRange(a, 24'h300000, 24'h3FFFFF);
		lspc = inRange(a, 24'h3C0000, 24'h3DFFFF);
		pal  = inRange(a, 24'h400000, 24'h7FFFFF);
		// Card answers on odd bytes
		card = inRange(a, 24'h800000, 24'hBFFFFF) && lo;
		srom = inRange(a, 24'hC00000, 24'hCFFFFF);
		sram = inRange(a, 24'hD00000, 24'hDFFFFF);
		// Same field order as memStrobes
		return ~{rd && lo && rom, rd && up && rom,
			rd && lo && port, rd && up && port, wr && lo && port, wr && up && port, port,
			rd && lo && wram, rd && up && wram, wr && lo && wram, wr && up && wram,
			rd && lo && srom, rd && up && srom,
			rd && lo && sram, rd && up && sram, wr && lo && sram, wr && up && sram,
			rd && up && lspc, wr && up && lspc,
			rd && card, wr && card, (rd || wr) && card,
			!b.nAs && pal,
			wr && lo && io && sub == 3'd4, wr && lo && io && sub == 3'd5,
			rd && lo && io && sub == 3'd0, rd && lo && io && sub == 3'd1};
	endfunction

	// Returns {dataOe, dataOut}
	function automatic logic [8:0] refRead(input busReq b, input padBits p1,
			input padBits p2, input logic cd1, input logic cd2, input logic wp,
			input logic mode, input dataByte reply);
		int sel;
		sel = regSel(b);
		// Icom slot drives the reply in either direction
		if (sel == 1) return {1'b1, reply};
		if (!b.rw) return 9'h000;
		if (sel == 0) return {1'b1, p1[7:0]};
		if (sel == 2) return {1'b1, p2[7:0]};
		if (sel == 4) return {1'b1, mode, wp, cd2, cd1, p2[9:8], p1[9:8]};
		return 9'h000;
	endfunction

	// Wait states of the access, -1 when pDtack ends it
	function automatic int refWait(input busReq b, input logic romWait,
			input logic pWait0, input logic pWait1);
		logic [23:0] a;
		a = {b.addr, 17'h0};
		if (inRange(a, 24'h800000, 24'hBFFFFF) && !b.nLds) return -1;
		if (a <= 24'h0FFFFF) return romWait ? 0 : romWaits;
		if (inRange(a, 24'h200000, 24'h2FFFFF)) return 2 * int'(!pWait1) + int'(!pWait0);
		return 0;
	endfunction

	assign expStrobes = refStrobes(cpuBus);
	assign {expOe, expData} = refRead(cpuBus, p1In, p2In, nCd1, nCd2, nWp, systemMode,
		replyModel);
	assign expWait   = refWait(cpuBus, nRomWait, nPWait0, nPWait1);
	assign expIcomWr = (regSel(cpuBus) == 1) && !cpuBus.rw;

	// Byte the Z80 last wrote
	always @(posedge clk68k or negedge arstN) begin
		if (!arstN) begin
			replyModel <= '0;
		end else if (!nSdZ80W) begin
			replyModel <= sddIn;
		end
	end

	// Card acknowledge comes at random
	always @(posedge clk68k) begin
		dtackRnd = $random(seed);
		pDtack <= dtackRnd[3];
	end

	task automatic startTest(input string name);
		portCheck.testName = name;
	endtask

	// One 68000 cycle, held until nDtack falls
	task automatic busCycle(input cpuAddr addr, input logic rw, input logic nUds,
			input logic nLds, input dataByte data);
		logic [31:0] padRnd;
		padRnd = $random(seed);
		@(posedge clk68k);
		cpuBus     <= {addr, rw, nLds, nUds, 1'b0};
		dataIn     <= data;
		p1In       <= padRnd[9:0];
		p2In       <= padRnd[19:10];
		{nCd1, nCd2, nWp, systemMode} <= padRnd[23:20];
		{nRomWait, nPWait0, nPWait1}  <= padRnd[26:24];
		do begin
			@(negedge clk68k);
		end while (nDtack);
		@(posedge clk68k);
		cpuBus.nAs <= 1'b1;
	endtask

	initial begin
		arstN      = 1'b0;
		cpuBus     = {7'h7F, 4'b1111};
		dataIn     = '0;
		sddIn      = '0;
		p1In       = '0;
		p2In       = '0;
		{nCd1, nCd2, nWp, systemMode} = 4'b1110;
		{nRomWait, nPWait0, nPWait1}  = 3'b111;
		pDtack     = 1'b0;
		{nSdZ80R, nSdZ80W, nSdZ80Clr} = 3'b111;
		startTest("reset");
		repeat (3) @(posedge clk68k);
		arstN <= 1'b1;
		repeat (2) @(posedge clk68k);

		startTest("decode");
		repeat (200) begin
			rnd = $random(seed);
			busCycle(rnd[6:0], rnd[7], rnd[8], rnd[9], rnd[17:10]);
		end

		// ctrl1, ctrl2 and statusB slots
		startTest("read port");
		repeat (30) begin
			rnd = $random(seed);
			reqAddr = (rnd[1:0] == 2'd0) ? 7'h18 : (rnd[1:0] == 2'd1) ? 7'h1A : 7'h1C;
			busCycle(reqAddr, 1'b1, 1'b0, rnd[2], 8'h00);
		end

		startTest("wait states");
		repeat (40) begin
			rnd = $random(seed);
			case (rnd[1:0])
				2'd0: reqAddr = {4'b0000, rnd[4:2]};
				2'd1: reqAddr = {4'b0010, rnd[4:2]};
				2'd2: reqAddr = {2'b10, rnd[6:2]};
				default: reqAddr = {4'b0001, rnd[4:2]};
			endcase
			busCycle(reqAddr, rnd[7], rnd[8], 1'b0, rnd[15:8]);
		end

		// Command out, Z80 reads it, then clears it
		// Low bit set keeps the command apart from the cleared latch
		startTest("sound command");
		rnd = $random(seed);
		busCycle(7'h19, 1'b0, 1'b0, 1'b1, {rnd[7:1], 1'b1});
		@(posedge clk68k);
		nSdZ80R <= 1'b0;
		repeat (2) @(posedge clk68k);
		nSdZ80R   <= 1'b1;
		nSdZ80Clr <= 1'b0;
		@(posedge clk68k);
		nSdZ80Clr <= 1'b1;
		nSdZ80R   <= 1'b0;
		@(posedge clk68k);
		nSdZ80R <= 1'b1;

		// Top bit set keeps the reply apart from the reset value
		startTest("sound reply");
		@(posedge clk68k);
		sddIn   <= {1'b1, rnd[14:8]};
		nSdZ80W <= 1'b0;
		@(posedge clk68k);
		nSdZ80W <= 1'b1;
		busCycle(7'h19, 1'b1, 1'b0, rnd[16], 8'h00);

		startTest("end");
		repeat (3) @(posedge clk68k);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Ten clocks per bus cycle is ample
	initial begin
		#(busCycles * 10 * clkPeriod);
		$display("Timeout: the run did not end within %0d ns", busCycles * 10 * clkPeriod);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: test/neoC1Checker.sv
// C1 output checker
`timescale 1ns/100ps

module neoC1Checker (
	input  logic             clk68k,
	input  logic             arstN,
	input  c1Pkg::busReq     cpuBus,
	input  c1Pkg::dataByte   dataIn,
	input  logic             pDtack,
	input  logic             nSdZ80R,
	input  logic             nSdZ80Clr,
	input  c1Pkg::memStrobes strobes,
	input  c1Pkg::dataByte   dataOut,
	input  logic             dataOe,
	input  logic             nDtack,
	input  c1Pkg::dataByte   sddOut,
	input  logic             sddOe,
	input  logic             nSdw,
	input  c1Pkg::memStrobes expStrobes,
	input  c1Pkg::dataByte   expData,
	input  logic             expOe,
	input  int               expWait,
	input  logic             expIcomWr,
	output int               errorCount,
	output int               checkCount
);
	import c1Pkg::*;

	// Set by the testbench as each test starts
	string testName = "";

	int errors = 0;
	int checks = 0;

	// DTACK timing model
	int   edgeIdx;
	int   nextEdge;
	logic inCycle;
	logic ackExp;

	// Command latch model
	logic    wrPrev;
	logic    sdwExp;
	dataByte cmdExp;

	assign errorCount = errors;
	assign checkCount = checks;

	// Edge 0 is the first edge that sees nAs low
	assign nextEdge = inCycle ? edgeIdx + 1 : 0;

	always @(posedge clk68k or negedge arstN) begin
		if (!arstN) begin
			inCycle <= 1'b0;
			ackExp  <= 1'b0;
			edgeIdx <= 0;
		end else if (cpuBus.nAs) begin
			// Master ended the cycle, acknowledge drops
			inCycle <= 1'b0;
			ackExp  <= 1'b0;
		end else begin
			inCycle <= 1'b1;
			edgeIdx <= nextEdge;
			if (expWait < 0) begin
				// Card sets its own length
				ackExp <= ackExp | pDtack;
			end else if (nextEdge >= expWait) begin
				ackExp <= 1'b1;
			end
		end
	end

	// One load and one nSdw pulse per icom write cycle
	always @(posedge clk68k or negedge arstN) begin
		if (!arstN) begin
			wrPrev <= 1'b0;
			sdwExp <= 1'b1;
			cmdExp <= '0;
		end else begin
			wrPrev <= expIcomWr;
			sdwExp <= !(expIcomWr && !wrPrev);
			if (expIcomWr && !wrPrev) begin
				cmdExp <= dataIn;
			end else if (!nSdZ80Clr) begin
				cmdExp <= '0;
			end
		end
	end

	task automatic compareOutput(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error %s %s: expected %h actual %h", testName, what, expected, actual);
		end
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clk68k) begin
		compareOutput("strobes", 32'(expStrobes), 32'(strobes));
		compareOutput("dataOe", 32'(expOe), 32'(dataOe));
		compareOutput("dataOut", 32'(expData), 32'(dataOut));
		compareOutput("nDtack", 32'(!ackExp), 32'(nDtack));
		compareOutput("nSdw", 32'(sdwExp), 32'(nSdw));
		compareOutput("sddOe", 32'(!nSdZ80R), 32'(sddOe));
		if (!nSdZ80R) begin
			compareOutput("sddOut", 32'(cmdExp), 32'(sddOut));
		end
	end

endmodule

// File: verilog/neoC1.sv
// Neo Geo C1 bus glue top level
`timescale 1ns/100ps

module neoC1 #(
	parameter c1Pkg::waitCount romWaitStates = 2'd1
) (
	input  logic             clk68k,
	input  logic             arstN,
	input  c1Pkg::busReq     cpuBus,
	input  c1Pkg::dataByte   dataIn,
	input  c1Pkg::padBits    p1In,
	input  c1Pkg::padBits    p2In,
	input  logic             nCd1,
	input  logic             nCd2,
	input  logic             nWp,
	input  logic             systemMode,
	input  logic             nRomWait,
	input  logic             nPWait0,
	input  logic             nPWait1,
	input  logic             pDtack,
	input  c1Pkg::dataByte   sddIn,
	input  logic             nSdZ80R,
	input  logic             nSdZ80W,
	input  logic             nSdZ80Clr,
	output c1Pkg::memStrobes strobes,
	output c1Pkg::dataByte   dataOut,
	output logic             dataOe,
	output logic             nDtack,
	output c1Pkg::dataByte   sddOut,
	output logic             sddOe,
	output logic             nSdw
);
	import c1Pkg::*;

	zoneBus  zones;
	dataByte soundReply;

	// Address side
	c1AddrDecode decode (
		.cpuBus  (cpuBus),
		.zones   (zones),
		.strobes (strobes)
	);

	// Bus acknowledge
	c1Wait #(
		.romWaitStates (romWaitStates)
	) waitGen (
		.clk68k   (clk68k),
		.arstN    (arstN),
		.nAs      (cpuBus.nAs),
		.zones    (zones),
		.nRomWait (nRomWait),
		.nPWait0  (nPWait0),
		.nPWait1  (nPWait1),
		.pDtack   (pDtack),
		.nDtack   (nDtack)
	);

	// Sound CPU mailbox
	c1SoundLatch soundLatch (
		.clk68k     (clk68k),
		.arstN      (arstN),
		.rw         (cpuBus.rw),
		.nIcom      (zones.nIcom),
		.dataIn     (dataIn),
		.sddIn      (sddIn),
		.nSdZ80R    (nSdZ80R),
		.nSdZ80W    (nSdZ80W),
		.nSdZ80Clr  (nSdZ80Clr),
		.sddOut     (sddOut),
		.sddOe      (sddOe),
		.nSdw       (nSdw),
		.soundReply (soundReply)
	);

	// Read data back to the 68000
	c1ReadPort readPort (
		.zones      (zones),
		.p1In       (p1In),
		.p2In       (p2In),
		.nCd1       (nCd1),
		.nCd2       (nCd2),
		.nWp        (nWp),
		.systemMode (systemMode),
		.soundReply (soundReply),
		.dataOut    (dataOut),
		.dataOe     (dataOe)
	);

endmodule

// File: verilog/c1ReadPort.sv
// Upper data lane read multiplexer
`timescale 1ns/100ps

module c1ReadPort (
	input  c1Pkg::zoneBus  zones,
	input  c1Pkg::padBits  p1In,
	input  c1Pkg::padBits  p2In,
	input  logic          nCd1,
	input  logic          nCd2,
	input  logic          nWp,
	input  logic          systemMode,
	input  c1Pkg::dataByte soundReply,
	output c1Pkg::dataByte dataOut,
	output logic          dataOe
);
	import c1Pkg::*;

	dataByte statusByte;
	logic    anyRead;

	// Status B layout, MSB first
	// mode, write protect, card detects, then select lines of both pads
	assign statusByte = {systemMode, nWp, nCd2, nCd1, p2In[9:8], p1In[9:8]};

	// Register zones already carry rw and nAs, except icom
	// Icom write data arrives on dataIn, so the reply lane is free to drive
	assign anyRead = ~(zones.nCtrl1 & zones.nCtrl2 & zones.nStatusB & zones.nIcom);

	always_comb begin
		dataOut = '0;
		if (!zones.nCtrl1) begin
			// Player 1 buttons
			dataOut = p1In[7:0];
		end else if (!zones.nCtrl2) begin
			// Player 2 buttons
			dataOut = p2In[7:0];
		end else if (!zones.nStatusB) begin
			dataOut = statusByte;
		end else if (!zones.nIcom) begin
			// Last byte from the Z80
			dataOut = soundReply;
		end
	end

	assign dataOe = anyRead;

endmodule

// File: verilog/c1SoundLatch.sv
// 68000 and Z80 sound command latches
`timescale 1ns/100ps

module c1SoundLatch (
	input  logic          clk68k,
	input  logic          arstN,
	input  logic          rw,
	input  logic          nIcom,
	input  c1Pkg::dataByte dataIn,
	input  c1Pkg::dataByte sddIn,
	input  logic          nSdZ80R,
	input  logic          nSdZ80W,
	input  logic          nSdZ80Clr,
	output c1Pkg::dataByte sddOut,
	output logic          sddOe,
	output logic          nSdw,
	output c1Pkg::dataByte soundReply
);
	import c1Pkg::*;

	dataByte cmdLatch;
	logic    icomWrite;
	logic    wrSeen;
	logic    loadCmd;

	// Icom zone is only live while nAs is low
	assign icomWrite = ~nIcom & ~rw;
	// First edge of the write only
	assign loadCmd   = icomWrite & ~wrSeen;

	// Command latch, 68000 to Z80
	always_ff @(posedge clk68k or negedge arstN) begin
		if (!arstN) begin
			cmdLatch <= '0;
			wrSeen   <= 1'b0;
			nSdw     <= 1'b1;
		end else begin
			wrSeen <= icomWrite;
			// One-cycle NMI request to the Z80
			nSdw   <= ~loadCmd;
			if (loadCmd) begin
				// A fresh command wins over a pending clear
				cmdLatch <= dataIn;
			end else if (!nSdZ80Clr) begin
				cmdLatch <= '0;
			end
		end
	end

	// Reply latch, Z80 to 68000
	always_ff @(posedge clk68k or negedge arstN) begin
		if (!arstN) begin
			soundReply <= '0;
		end else if (!nSdZ80W) begin
			soundReply <= sddIn;
		end
	end

	// Z80 read of the command
	assign sddOe  = ~nSdZ80R;
	assign sddOut = nSdZ80R ? '0 : cmdLatch;

	// Each write yields a single pulse
	sdwSinglePulse: assert property (@(posedge clk68k) disable iff (!arstN)
		!nSdw |=> nSdw)
		else $error("c1SoundLatch: nSdw low for two cycles");

endmodule

// File: verilog/c1Wait.sv
// 68000 DTACK wait-state generator
`timescale 1ns/100ps

module c1Wait #(
	parameter c1Pkg::waitCount romWaitStates = 2'd1
) (
	input  logic         clk68k,
	input  logic         arstN,
	input  logic         nAs,
	input  c1Pkg::zoneBus zones,
	input  logic         nRomWait,
	input  logic         nPWait0,
	input  logic         nPWait1,
	input  logic         pDtack,
	output logic         nDtack
);
	import c1Pkg::*;

	waitState state;
	waitCount count;
	waitCount zoneWait;
	logic     cardZone;

	assign cardZone = ~zones.nCard;

	// Wait count of the zone being accessed
	always_comb begin
		if (!zones.nRom) begin
			zoneWait = nRomWait ? 2'd0 : romWaitStates;
		end else if (!zones.nPort) begin
			// Port slot requests 0 to 3 waits
			zoneWait = {~nPWait1, ~nPWait0};
		end else begin
			zoneWait = 2'd0;
		end
	end

	always_ff @(posedge clk68k or negedge arstN) begin
		if (!arstN) begin
			state <= sIdle;
			count <= '0;
		end else begin
			case (state)
				sIdle: begin
					// Edge 0 of a bus cycle
					if (!nAs) begin
						if (cardZone) begin
							state <= pDtack ? sAck : sCount;
						end else if (zoneWait == 2'd0) begin
							state <= sAck;
						end else begin
							state <= sCount;
							count <= zoneWait - 2'd1;
						end
					end
				end
				sCount: begin
					if (nAs) begin
						// Aborted cycle
						state <= sIdle;
					end else if (cardZone) begin
						// Card decides its own length
						if (pDtack) begin
							state <= sAck;
						end
					end else if (count == 2'd0) begin
						state <= sAck;
					end else begin
						count <= count - 2'd1;
					end
				end
				sAck: begin
					// Hold acknowledge until the master ends the cycle
					if (nAs) begin
						state <= sIdle;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	assign nDtack = (state != sAck);

	// No acknowledge may follow a sampled idle bus
	dtackAfterAs: assert property (@(posedge clk68k) disable iff (!arstN)
		nAs |=> nDtack)
		else $error("c1Wait: nDtack low after nAs high");

endmodule

// File: verilog/c1AddrDecode.sv
// 68000 zone and strobe decoder
`timescale 1ns/100ps

module c1AddrDecode (
	input  c1Pkg::busReq     cpuBus,
	output c1Pkg::zoneBus    zones,
	output c1Pkg::memStrobes strobes
);

	// Named address bits
	logic a23, a22, a21, a20, a19, a18, a17;
	logic rw, nLds, nUds, nAs;

	// Internal zones, not exported
	logic nIoZone;
	logic nC1Regs;

	assign {a23, a22, a21, a20, a19, a18, a17} = cpuBus.addr;
	assign rw   = cpuBus.rw;
	assign nLds = cpuBus.nLds;
	assign nUds = cpuBus.nUds;
	assign nAs  = cpuBus.nAs;

	// 1 MB zones in the low 4 MB
	// 000000 to 0FFFFF
	assign zones.nRom  = a23 | a22 | a21 | a20;
	// 100000 to 1FFFFF
	assign zones.nWram = a23 | a22 | a21 | ~a20;
	// 200000 to 2FFFFF
	assign zones.nPort = a23 | a22 | ~a21 | a20;
	// 300000 to 3FFFFF, split below
	assign nIoZone     = a23 | a22 | ~a21 | ~a20;

	// C1 registers sit on even bytes only, live during the bus cycle
	assign nC1Regs = nUds | nIoZone | nAs;

	// 300000 to 31FFFF, player 1, read only
	assign zones.nCtrl1   = nC1Regs | ~rw | a19 | a18 | a17;
	// 320000 to 33FFFF, sound latches, both directions
	assign zones.nIcom    = nC1Regs | a19 | a18 | ~a17;
	// 340000 to 35FFFF, player 2, read only
	assign zones.nCtrl2   = nC1Regs | ~rw | a19 | ~a18 | a17;
	// 380000 to 39FFFF, status B, read only
	assign zones.nStatusB = nC1Regs | ~rw | ~a19 | a18 | a17;

	// 3C0000 to 3DFFFF, video controller
	assign zones.nLspc = nIoZone | ~a19 | ~a18 | a17;

	// 400000 to 7FFFFF, palette RAM
	assign zones.nPal  = a23 | ~a22;
	// 800000 to BFFFFF, memory card on odd bytes
	assign zones.nCard = nLds | ~a23 | a22;
	// C00000 to CFFFFF, system ROM
	assign zones.nSrom = ~a23 | ~a22 | a21 | a20;
	// D00000 to DFFFFF, backup SRAM
	assign zones.nSram = ~a23 | ~a22 | a21 | ~a20;

	// Cartridge ROM, read only
	assign strobes.nRomOeL = ~rw | nLds | zones.nRom | nAs;
	assign strobes.nRomOeU = ~rw | nUds | zones.nRom | nAs;

	// Expansion port
	assign strobes.nPortOeL  = ~rw | nLds | zones.nPort | nAs;
	assign strobes.nPortOeU  = ~rw | nUds | zones.nPort | nAs;
	assign strobes.nPortWeL  = rw | nLds | zones.nPort | nAs;
	assign strobes.nPortWeU  = rw | nUds | zones.nPort | nAs;
	// Address select follows the zone alone
	assign strobes.nPortAdrs = zones.nPort;

	// Work RAM
	assign strobes.nWrL = ~rw | nLds | zones.nWram | nAs;
	assign strobes.nWrU = ~rw | nUds | zones.nWram | nAs;
	assign strobes.nWwL = rw | nLds | zones.nWram | nAs;
	assign strobes.nWwU = rw | nUds | zones.nWram | nAs;

	// System ROM
	assign strobes.nSromOeL = ~rw | nLds | zones.nSrom | nAs;
	assign strobes.nSromOeU = ~rw | nUds | zones.nSrom | nAs;

	// Backup SRAM
	assign strobes.nSramOeL = ~rw | nLds | zones.nSram | nAs;
	assign strobes.nSramOeU = ~rw | nUds | zones.nSram | nAs;
	assign strobes.nSramWeL = rw | nLds | zones.nSram | nAs;
	assign strobes.nSramWeU = rw | nUds | zones.nSram | nAs;

	// Video controller on the upper lane only
	assign strobes.nLspOe = ~rw | nUds | zones.nLspc | nAs;
	assign strobes.nLspWe = rw | nUds | zones.nLspc | nAs;

	// Memory card, common enable on either access
	assign strobes.nCrdO = ~rw | zones.nCard | nAs;
	assign strobes.nCrdW = rw | zones.nCard | nAs;
	assign strobes.nCrdC = strobes.nCrdO & strobes.nCrdW;

	// Palette, both directions
	assign strobes.nPal = zones.nPal | nAs;

	// DIP switch reads on odd bytes, 30xxxx and 32xxxx
	assign strobes.nDipRd0 = nAs | nLds | ~rw | nIoZone | a19 | a18 | a17;
	assign strobes.nDipRd1 = nAs | nLds | ~rw | nIoZone | a19 | a18 | ~a17;
	// Bit latch writes on odd bytes, 38xxxx and 3Axxxx
	assign strobes.nBitW0  = nAs | nLds | rw | nIoZone | ~a19 | a18 | a17;
	assign strobes.nBitW1  = nAs | nLds | rw | nIoZone | ~a19 | a18 | ~a17;

	// Main memory zones never overlap within a bus cycle
	memZoneExclusive: assert property (@(posedge nAs)
		$onehot0(~{zones.nRom, zones.nWram, zones.nPort, zones.nSrom, zones.nSram}))
		else $error("c1AddrDecode: overlapping memory zones");

endmodule

// File: verilog/c1Pkg.sv
// C1 glue chip shared types
package c1Pkg;

	// 68000 address lines A23 down to A17
	typedef logic [6:0] cpuAddr;

	// One byte on the upper data lane or on SDD
	typedef logic [7:0] dataByte;

	// Player port, eight buttons then two select lines on top
	typedef logic [9:0] padBits;

	// Number of inserted wait states
	typedef logic [1:0] waitCount;

	// One 68000 bus request, held from nAs fall to nAs rise
	typedef struct packed {
		cpuAddr addr;
		logic   rw;
		logic   nLds;
		logic   nUds;
		logic   nAs;
	} busReq;

	// Decoded zones, all active low
	typedef struct packed {
		logic nRom;
		logic nWram;
		logic nPort;
		logic nLspc;
		logic nCard;
		logic nSrom;
		logic nSram;
		logic nPal;
		logic nCtrl1;
		logic nCtrl2;
		logic nStatusB;
		logic nIcom;
	} zoneBus;

	// Memory and peripheral strobes, all active low
	typedef struct packed {
		logic nRomOeL, nRomOeU;
		logic nPortOeL, nPortOeU, nPortWeL, nPortWeU, nPortAdrs;
		logic nWrL, nWrU, nWwL, nWwU;
		logic nSromOeL, nSromOeU;
		logic nSramOeL, nSramOeU, nSramWeL, nSramWeU;
		logic nLspOe, nLspWe;
		logic nCrdO, nCrdW, nCrdC;
		logic nPal;
		logic nBitW0, nBitW1, nDipRd0, nDipRd1;
	} memStrobes;

	// DTACK generator states
	typedef enum logic [1:0] {
		sIdle,
		sCount,
		sAck
	} waitState;

endpackage
